// File: hw/apb_pkg.sv
// apb bus types
package apb_pkg;

	typedef logic [31:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// master to slave
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// slave to master, no pslverr
	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
	} apb_rsp_t;

endpackage

// File: hw/noc_pkg.sv
// noc packet definitions
package noc_pkg;

	import apb_pkg::*;

	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  src_id_t;
	typedef logic [7:0]  len_t;
	typedef logic [31:0] word_t;

	// top three bits of the command byte
	typedef enum logic [2:0] {
		OP_READ  = 3'b001,
		OP_WRITE = 3'b011
	} opcode_t;

	localparam int MAX_WORDS  = 3;
	localparam int WORD_BYTES = 4;

	// low nibble 1000 means one address byte only
	localparam logic [3:0]  SHORT_ADDR_NIB  = 4'b1000;
	localparam logic [23:0] SHORT_ADDR_FILL = 24'hff_ffff;

	localparam byte_t RESP_READ  = 8'h40;
	localparam byte_t RESP_WRITE = 8'h80;
	localparam byte_t RESP_END   = 8'he0;
	localparam byte_t LINK_IDLE  = 8'h00;

	// count is 1..MAX_WORDS
	typedef struct packed {
		opcode_t    opcode;
		src_id_t    src_id;
		apb_addr_t  addr;
		logic [1:0] count;
		word_t      wdata;
	} noc_req_t;

	// word 0 sits in the low bits of rdata
	typedef struct packed {
		opcode_t                opcode;
		src_id_t                src_id;
		logic [1:0]             count;
		word_t [MAX_WORDS-1:0]  rdata;
	} noc_resp_t;

endpackage

// File: hw/noc_req_decode.sv
// noc request parser
`timescale 1ns/1ps

module noc_req_decode (
	input  logic              clk,
	input  logic              rst,
	input  logic              cmd_in,
	input  noc_pkg::byte_t    data_in,
	output logic              req_push,
	output noc_pkg::noc_req_t req
);

	import noc_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SRC,
		ST_ADDR,
		ST_LEN,
		ST_WDATA
	} dec_state_t;

	dec_state_t state;
	logic [1:0] byte_idx;
	logic       short_addr;
	logic       cmd_ok;
	opcode_t    cmd_op;
	len_t       len_byte;

	assign cmd_op   = opcode_t'(data_in[7:5]);
	assign cmd_ok   = cmd_in && (cmd_op == OP_READ || cmd_op == OP_WRITE);
	assign len_byte = data_in;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state      <= ST_IDLE;
			byte_idx   <= 2'd0;
			short_addr <= 1'b0;
			req_push   <= 1'b0;
		end
		else
		begin
			req_push <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					// unknown opcodes never leave idle
					if (cmd_ok)
					begin
						short_addr <= (data_in[3:0] == SHORT_ADDR_NIB);
						state      <= ST_SRC;
					end
				end
				ST_SRC:
				begin
					byte_idx <= 2'd0;
					state    <= ST_ADDR;
				end
				ST_ADDR:
				begin
					byte_idx <= byte_idx + 2'd1;
					if (short_addr || byte_idx == 2'd3)
						state <= ST_LEN;
				end
				ST_LEN:
				begin
					byte_idx <= 2'd0;
					if (req.opcode == OP_WRITE)
						state <= ST_WDATA;
					else
					begin
						req_push <= 1'b1;
						state    <= ST_IDLE;
					end
				end
				ST_WDATA:
				begin
					byte_idx <= byte_idx + 2'd1;
					if (byte_idx == 2'd3)
					begin
						req_push <= 1'b1;
						state    <= ST_IDLE;
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// fields fill in as their bytes go by, lsb first
	always_ff @(posedge clk)
	begin
		case (state)
			ST_IDLE:
				if (cmd_ok)
					req.opcode <= cmd_op;
			ST_SRC:
				req.src_id <= data_in;
			ST_ADDR:
				if (short_addr)
					req.addr <= {SHORT_ADDR_FILL, data_in};
				else
					req.addr[{byte_idx, 3'b000} +: 8] <= data_in;
			ST_LEN:
				// writes are always a single word
				if (req.opcode == OP_WRITE)
					req.count <= 2'd1;
				else
					req.count <= len_byte[3:2];
			ST_WDATA:
				req.wdata[{byte_idx, 3'b000} +: 8] <= data_in;
		endcase
	end

endmodule

// File: hw/req_fifo.sv
// request queue
`timescale 1ns/1ps

module req_fifo #(
	parameter int DEPTH_LOG2 = 2
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              push,
	input  noc_pkg::noc_req_t din,
	input  logic              pop,
	output noc_pkg::noc_req_t dout,
	output logic              full,
	output logic              empty
);

	import noc_pkg::*;

	noc_req_t mem [1 << DEPTH_LOG2];

	// extra msb tells a full ring from an empty one
	logic [DEPTH_LOG2:0] wr_ptr;
	logic [DEPTH_LOG2:0] rd_ptr;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
		(wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

	// show-ahead head
	assign dout = mem[rd_ptr[DEPTH_LOG2-1:0]];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			// push into a full queue is dropped
			if (push && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push && !full)
			mem[wr_ptr[DEPTH_LOG2-1:0]] <= din;
	end

endmodule

// File: hw/apb_execute.sv
// apb transfer engine
`timescale 1ns/1ps

module apb_execute (
	input  logic               clk,
	input  logic               rst,
	input  noc_pkg::noc_req_t  req_head,
	input  logic               req_empty,
	output logic               req_pop,
	output apb_pkg::apb_req_t  apb_req,
	input  apb_pkg::apb_rsp_t  apb_rsp,
	output logic               resp_valid,
	output noc_pkg::noc_resp_t resp,
	input  logic               resp_ready
);

	import apb_pkg::*;
	import noc_pkg::*;

	typedef enum logic [1:0] {
		EX_IDLE,
		EX_SETUP,
		EX_ACCESS,
		EX_HANDOFF
	} ex_state_t;

	ex_state_t             state;
	logic [1:0]            word_idx;
	logic                  last_word;
	apb_addr_t             cur_addr;
	word_t [MAX_WORDS-1:0] rdata_q;

	assign last_word = (word_idx == req_head.count - 2'd1);

	// head stays put until the pop, so it drives the bus directly
	always_comb
	begin
		apb_req.psel    = (state == EX_SETUP) || (state == EX_ACCESS);
		apb_req.penable = (state == EX_ACCESS);
		apb_req.pwrite  = (req_head.opcode == OP_WRITE);
		apb_req.paddr   = cur_addr;
		apb_req.pwdata  = req_head.wdata;
	end

	always_comb
	begin
		resp.opcode = req_head.opcode;
		resp.src_id = req_head.src_id;
		resp.count  = req_head.count;
		resp.rdata  = rdata_q;
	end

	assign resp_valid = (state == EX_HANDOFF);
	assign req_pop    = resp_valid && resp_ready;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state    <= EX_IDLE;
			word_idx <= 2'd0;
		end
		else
		begin
			case (state)
				EX_IDLE:
				begin
					word_idx <= 2'd0;
					if (!req_empty)
						state <= EX_SETUP;
				end
				EX_SETUP:
					state <= EX_ACCESS;
				EX_ACCESS:
				begin
					// wait states hold the access phase
					if (apb_rsp.pready)
					begin
						if (last_word)
							state <= EX_HANDOFF;
						else
						begin
							word_idx <= word_idx + 2'd1;
							state    <= EX_SETUP;
						end
					end
				end
				EX_HANDOFF:
					if (resp_ready)
						state <= EX_IDLE;
				default:
					state <= EX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == EX_IDLE)
			cur_addr <= req_head.addr;
		else if (state == EX_ACCESS && apb_rsp.pready)
		begin
			cur_addr <= cur_addr + apb_addr_t'(WORD_BYTES);
			if (!apb_req.pwrite)
				rdata_q[word_idx] <= apb_rsp.prdata;
		end
	end

endmodule

// File: hw/noc_resp_send.sv
// noc response serializer
`timescale 1ns/1ps

module noc_resp_send (
	input  logic               clk,
	input  logic               rst,
	input  logic               resp_valid,
	input  noc_pkg::noc_resp_t resp,
	output logic               resp_ready,
	output logic               cmd_out,
	output noc_pkg::byte_t     data_out
);

	import noc_pkg::*;

	noc_resp_t resp_q;
	logic      busy;
	logic      is_read;
	logic [3:0] byte_cnt;
	logic [3:0] last_cnt;
	logic [3:0] data_idx;
	logic [MAX_WORDS*WORD_BYTES*8-1:0] rdata_bits;

	assign is_read    = (resp_q.opcode == OP_READ);
	assign rdata_bits = resp_q.rdata;
	assign data_idx   = byte_cnt - 4'd2;
	assign resp_ready = !busy;

	// read: code, id, 4n data, end marker; write: code, id
	assign last_cnt = is_read ? 4'(2 + WORD_BYTES * resp_q.count) : 4'd1;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			busy     <= 1'b0;
			byte_cnt <= 4'd0;
		end
		else if (!busy)
		begin
			byte_cnt <= 4'd0;
			if (resp_valid)
				busy <= 1'b1;
		end
		else if (byte_cnt == last_cnt)
			busy <= 1'b0;
		else
			byte_cnt <= byte_cnt + 4'd1;
	end

	always_ff @(posedge clk)
	begin
		if (resp_valid && resp_ready)
			resp_q <= resp;
	end

	// idle link shows cmd high with a zero byte
	always_comb
	begin
		cmd_out  = 1'b1;
		data_out = LINK_IDLE;
		if (busy)
		begin
			if (byte_cnt == 4'd0)
				data_out = is_read ? RESP_READ : RESP_WRITE;
			else if (byte_cnt == 4'd1)
			begin
				cmd_out  = 1'b0;
				data_out = resp_q.src_id;
			end
			else if (byte_cnt == last_cnt)
				data_out = RESP_END;
			else
			begin
				cmd_out  = 1'b0;
				data_out = rdata_bits[{data_idx, 3'b000} +: 8];
			end
		end
	end

endmodule

// File: hw/noc_bridge.sv
// noc to apb bridge
`timescale 1ns/1ps

module noc_bridge (
	input  logic              clk,
	input  logic              rst,
	input  logic              cmd_in,
	input  noc_pkg::byte_t    data_in,
	output logic              cmd_out,
	output noc_pkg::byte_t    data_out,
	output apb_pkg::apb_req_t apb_req,
	input  apb_pkg::apb_rsp_t apb_rsp
);

	import noc_pkg::*;

	logic      req_push;
	logic      req_pop;
	logic      req_empty;
	logic      resp_valid;
	logic      resp_ready;
	noc_req_t  req;
	noc_req_t  req_head;
	noc_resp_t resp;

	noc_req_decode u_decode (
		.clk      (clk),
		.rst      (rst),
		.cmd_in   (cmd_in),
		.data_in  (data_in),
		.req_push (req_push),
		.req      (req)
	);

	// full is not fed back, the link has no flow control
	req_fifo #(
		.DEPTH_LOG2 (2)
	) u_fifo (
		.clk   (clk),
		.rst   (rst),
		.push  (req_push),
		.din   (req),
		.pop   (req_pop),
		.dout  (req_head),
		.full  (),
		.empty (req_empty)
	);

	apb_execute u_execute (
		.clk        (clk),
		.rst        (rst),
		.req_head   (req_head),
		.req_empty  (req_empty),
		.req_pop    (req_pop),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.resp_valid (resp_valid),
		.resp       (resp),
		.resp_ready (resp_ready)
	);

	noc_resp_send u_send (
		.clk        (clk),
		.rst        (rst),
		.resp_valid (resp_valid),
		.resp       (resp),
		.resp_ready (resp_ready),
		.cmd_out    (cmd_out),
		.data_out   (data_out)
	);

endmodule

// File: dv/clk_rst_gen.sv
// clock and reset source
`timescale 1ns/1ps

module clk_rst_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2.0) clk = ~clk;
	end

	// release just after an edge
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

// File: dv/apb_mem_model.sv
// apb slave memory model
`timescale 1ns/1ps

module apb_mem_model #(
	parameter logic [7:0] SEED = 8'd46
) (
	input  logic              clk,
	input  logic              rst,
	input  apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp
);

	import apb_pkg::*;

	apb_data_t  mem [64];
	logic [7:0] lfsr;
	logic       waited;
	logic       access;
	logic [5:0] idx;

	// galois form of x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		logic [7:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 8'hb8;
		return n;
	endfunction

	// every word index bit shows up in the fill
	initial
	begin
		for (int i = 0; i < 64; i++)
			mem[i] = {8'hd0 + 8'(i), 8'(i), 8'(~i), 8'(i * 3)};
	end

	// aliases on the low address bits
	assign access = apb_req.psel && apb_req.penable;
	assign idx    = apb_req.paddr[7:2];

	// lfsr bit of one costs a single wait state
	always_comb
	begin
		apb_rsp.prdata = mem[idx];
		apb_rsp.pready = waited || !lfsr[0];
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			lfsr   <= SEED;
			waited <= 1'b0;
		end
		else if (access)
		begin
			if (apb_rsp.pready)
			begin
				waited <= 1'b0;
				lfsr   <= lfsr_step(lfsr);
			end
			else
				waited <= 1'b1;
		end
	end

	always @(posedge clk)
	begin
		if (access && apb_rsp.pready && apb_req.pwrite)
			mem[idx] <= apb_req.pwdata;
	end

endmodule

// File: dv/noc_bridge_tb.sv
// noc bridge testbench
`timescale 1ns/1ps

module noc_bridge_tb;

	import apb_pkg::*;
	import noc_pkg::*;

	// drain waits for all responses before the next entry
	typedef struct packed {
		logic [2:0] op;
		logic       short_addr;
		src_id_t    id;
		apb_addr_t  addr;
		len_t       len;
		word_t      wdata;
		logic       drain;
	} stim_t;

	localparam int CLK_PERIOD_NS  = 8;
	localparam int NUM_STIM       = 14;
	localparam int TIMEOUT_CYCLES = 400 * NUM_STIM + 4;

	logic     clk;
	logic     rst;
	logic     cmd_in;
	byte_t    data_in;
	logic     cmd_out;
	byte_t    data_out;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	stim_t      stim_tab [NUM_STIM];
	word_t      shadow [64];
	byte_t      exp_code [$];
	src_id_t    exp_id [$];
	logic [1:0] exp_count [$];
	word_t      exp_words [$];
	int         resp_expected = 0;
	int         resp_seen = 0;
	int         value_errs = 0;
	int         frame_errs = 0;
	int         bus_errs = 0;

	clk_rst_gen #(
		.PERIOD_NS    (CLK_PERIOD_NS),
		.RESET_CYCLES (4)
	) u_clk (
		.clk (clk),
		.rst (rst)
	);

	noc_bridge dut (
		.clk      (clk),
		.rst      (rst),
		.cmd_in   (cmd_in),
		.data_in  (data_in),
		.cmd_out  (cmd_out),
		.data_out (data_out),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp)
	);

	apb_mem_model #(
		.SEED (8'd46)
	) u_mem (
		.clk     (clk),
		.rst     (rst),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	function automatic word_t fill_word(input int i);
		return {8'hd0 + 8'(i), 8'(i), 8'(~i), 8'(i * 3)};
	endfunction

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp)
		begin
			value_errs++;
			$display("** Error at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp)
		begin
			value_errs++;
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_cmd(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			value_errs++;
			$display("** Error at %0t ns: cmd_out on the %s is %b, expected %b",
				$time, what, got, exp);
		end
	endtask

	task automatic send_byte(input logic cmd, input byte_t b);
		@(posedge clk);
		#1;
		cmd_in  = cmd;
		data_in = b;
	endtask

	// expectations follow table order, the bridge answers in order
	task automatic send_packet(input stim_t s);
		apb_addr_t a;
		apb_addr_t wa;
		a = s.short_addr ? {SHORT_ADDR_FILL, s.addr[7:0]} : s.addr;
		if (s.op == OP_WRITE)
		begin
			shadow[a[7:2]] = s.wdata;
			exp_code.push_back(RESP_WRITE);
			exp_id.push_back(s.id);
			exp_count.push_back(2'd0);
			resp_expected++;
		end
		else if (s.op == OP_READ)
		begin
			exp_code.push_back(RESP_READ);
			exp_id.push_back(s.id);
			exp_count.push_back(2'(s.len / WORD_BYTES));
			for (int k = 0; k < s.len / WORD_BYTES; k++)
			begin
				wa = a + apb_addr_t'(WORD_BYTES * k);
				exp_words.push_back(shadow[wa[7:2]]);
			end
			resp_expected++;
		end
		send_byte(1'b1, {s.op, 1'b0, s.short_addr ? SHORT_ADDR_NIB : 4'b0000});
		send_byte(1'b0, s.id);
		if (s.short_addr)
			send_byte(1'b0, s.addr[7:0]);
		else
			for (int k = 0; k < 4; k++)
				send_byte(1'b0, s.addr[8 * k +: 8]);
		send_byte(1'b0, s.len);
		if (s.op == OP_WRITE)
			for (int k = 0; k < 4; k++)
				send_byte(1'b0, s.wdata[8 * k +: 8]);
	endtask

	// called on the code byte, returns after the last byte
	task automatic parse_packet();
		byte_t      code;
		byte_t      got [$];
		word_t      words [MAX_WORDS];
		logic [1:0] cnt;
		code = data_out;
		if (exp_code.size() == 0)
		begin
			frame_errs++;
			$display("unexpected response packet with code %02h at %0t ns", code, $time);
			return;
		end
		cnt = exp_count.pop_front();
		for (int k = 0; k < cnt; k++)
			words[k] = exp_words.pop_front();
		check_byte(code, exp_code.pop_front(), "response code");
		@(negedge clk);
		check_cmd(cmd_out, 1'b0, "response id");
		check_byte(data_out, exp_id.pop_front(), "response id");
		if (code == RESP_READ)
		begin
			@(negedge clk);
			while (cmd_out !== 1'b1 && got.size() < MAX_WORDS * WORD_BYTES)
			begin
				got.push_back(data_out);
				@(negedge clk);
			end
			check_cmd(cmd_out, 1'b1, "end marker");
			check_byte(data_out, RESP_END, "end marker");
			if (got.size() % WORD_BYTES != 0)
			begin
				frame_errs++;
				$display("read data at %0t ns ends in the middle of a word", $time);
			end
			check_count(2'(got.size() / WORD_BYTES), cnt, "read word count");
			for (int k = 0; k < got.size() && k < cnt * WORD_BYTES; k++)
				check_byte(got[k], byte_t'(words[k / WORD_BYTES] >> (8 * (k % WORD_BYTES))),
					"read data byte");
		end
		resp_seen++;
	endtask

	// between packets the link must show idle
	initial
	begin
		@(negedge rst);
		forever
		begin
			@(negedge clk);
			if (cmd_out !== 1'b1)
			begin
				frame_errs++;
				$display("link byte %02h at %0t ns arrived outside a packet", data_out, $time);
			end
			else if (data_out !== LINK_IDLE)
				parse_packet();
		end
	end

	// every access phase follows a setup phase on the same address
	initial
	begin
		logic      prev_sel;
		logic      prev_en;
		logic      prev_rdy;
		apb_addr_t prev_addr;
		prev_sel  = 1'b0;
		prev_en   = 1'b0;
		prev_rdy  = 1'b0;
		prev_addr = '0;
		forever
		begin
			@(negedge clk);
			if (rst)
			begin
				if (apb_req.psel !== 1'b0 || apb_req.penable !== 1'b0)
				begin
					bus_errs++;
					$display("apb select or enable is high during reset at %0t ns", $time);
				end
			end
			else if (apb_req.penable === 1'b1)
			begin
				if (apb_req.psel !== 1'b1 || !prev_sel || (prev_en && prev_rdy) ||
					apb_req.paddr !== prev_addr)
				begin
					bus_errs++;
					$display("apb access phase at %0t ns has no matching setup phase", $time);
				end
			end
			else if (prev_en && !prev_rdy)
			begin
				bus_errs++;
				$display("apb access phase ended before pready at %0t ns", $time);
			end
			prev_sel  = apb_req.psel;
			prev_en   = apb_req.penable;
			prev_rdy  = apb_rsp.pready;
			prev_addr = apb_req.paddr;
		end
	end

	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD_NS);
		$display("timeout: the bridge gave only %0d of %0d responses", resp_seen, resp_expected);
		$display("errors: %0d value, %0d framing, %0d bus", value_errs, frame_errs, bus_errs);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		cmd_in  = 1'b0;
		data_in = LINK_IDLE;
		for (int i = 0; i < 64; i++)
			shadow[i] = fill_word(i);
		stim_tab[0]  = '{3'b011, 1'b0, 8'h11, 32'h0000_0010, 8'd4, 32'hcafe_0123, 1'b1};
		stim_tab[1]  = '{3'b001, 1'b0, 8'h12, 32'h0000_0010, 8'd4, 32'h0000_0000, 1'b1};
		stim_tab[2]  = '{3'b001, 1'b0, 8'h21, 32'h0000_0020, 8'd8, 32'h0000_0000, 1'b1};
		stim_tab[3]  = '{3'b001, 1'b0, 8'h22, 32'h0000_0080, 8'd12, 32'h0000_0000, 1'b1};
		stim_tab[4]  = '{3'b011, 1'b1, 8'h31, 32'h0000_0044, 8'd4, 32'h1234_5678, 1'b1};
		stim_tab[5]  = '{3'b001, 1'b1, 8'h32, 32'h0000_0044, 8'd4, 32'h0000_0000, 1'b1};
		// long address, same word as the short one
		stim_tab[6]  = '{3'b001, 1'b0, 8'h33, 32'h0000_0044, 8'd4, 32'h0000_0000, 1'b1};
		// unknown opcode, no answer
		stim_tab[7]  = '{3'b111, 1'b0, 8'h5a, 32'h0000_0050, 8'd4, 32'h0000_0000, 1'b1};
		// four back to back fill the queue
		stim_tab[8]  = '{3'b011, 1'b0, 8'h81, 32'h0000_0040, 8'd4, 32'h0bad_f00d, 1'b0};
		stim_tab[9]  = '{3'b001, 1'b1, 8'h82, 32'h0000_0040, 8'd8, 32'h0000_0000, 1'b0};
		stim_tab[10] = '{3'b001, 1'b0, 8'h83, 32'h0000_00fc, 8'd12, 32'h0000_0000, 1'b0};
		stim_tab[11] = '{3'b011, 1'b1, 8'h84, 32'h0000_0004, 8'd4, 32'h7e57_a11b, 1'b1};
		stim_tab[12] = '{3'b001, 1'b0, 8'h91, 32'h0000_0004, 8'd4, 32'h0000_0000, 1'b0};
		stim_tab[13] = '{3'b001, 1'b0, 8'h92, 32'h1000_0010, 8'd12, 32'h0000_0000, 1'b1};
		@(negedge rst);
		repeat (4)
			@(posedge clk);
		foreach (stim_tab[i])
		begin
			send_packet(stim_tab[i]);
			if (stim_tab[i].drain)
			begin
				send_byte(1'b0, LINK_IDLE);
				while (resp_seen < resp_expected)
					@(negedge clk);
				repeat (8)
					@(posedge clk);
			end
		end
		$display("errors: %0d value, %0d framing, %0d bus", value_errs, frame_errs, bus_errs);
		if (value_errs == 0 && frame_errs == 0 && bus_errs == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: noc_bridge.f
hw/apb_pkg.sv
hw/noc_pkg.sv
hw/noc_req_decode.sv
hw/req_fifo.sv
hw/apb_execute.sv
hw/noc_resp_send.sv
hw/noc_bridge.sv
dv/clk_rst_gen.sv
dv/apb_mem_model.sv
dv/noc_bridge_tb.sv

// File: Bender.yml
package:
  name: noc_bridge

sources:
  - hw/apb_pkg.sv
  - hw/noc_pkg.sv
  - hw/noc_req_decode.sv
  - hw/req_fifo.sv
  - hw/apb_execute.sv
  - hw/noc_resp_send.sv
  - hw/noc_bridge.sv
  - target: test
    files:
      - dv/clk_rst_gen.sv
      - dv/apb_mem_model.sv
      - dv/noc_bridge_tb.sv
